//--- design/alu_unit.sv
`timescale 1ns/1ps

`include "rs_macros.svh"

module alu_unit import rs_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // issue slot from the station
    input  rs_entry_t issue,
    // lane 0 broadcast
    output wakeup_t   result
);

    logic                    take;
    logic [`XLEN-1:0]        alu_value;
    logic                    out_valid;
    logic [`ROB_TAG_LEN-1:0] out_tag;
    logic [`XLEN-1:0]        out_value;

    // only alu-kind instructions land here
    assign take = issue.valid && (issue.insn.fu == fu_alu);

    always_comb begin
        unique case (issue.insn.op)
            op_add:  alu_value = issue.insn.value_src1 + issue.insn.value_src2;
            op_sub:  alu_value = issue.insn.value_src1 - issue.insn.value_src2;
            op_xor:  alu_value = issue.insn.value_src1 ^ issue.insn.value_src2;
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
        end
    end

    // payload just follows the issue slot
    always_ff @(posedge clk) begin
        out_tag   <= issue.insn.insn_tag;
        out_value <= alu_value;
    end

    assign result = '{valid: out_valid, tag: out_tag, value: out_value};

    // dispatch routes every op_mul to the multiplier
    a_no_mul_op: assert property (@(posedge clk) disable iff (reset) take |-> issue.insn.op != op_mul)
        else $error("alu got a multiply");

endmodule

//--- design/mul_unit.sv
`timescale 1ns/1ps

`include "rs_macros.svh"

module mul_unit import rs_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // issue slot from the station
    input  rs_entry_t issue,
    // lane 1 broadcast, three cycles after issue
    output wakeup_t   result
);

    logic take;

    // stage 1, operands captured
    logic                    s1_valid;
    logic [`ROB_TAG_LEN-1:0] s1_tag;
    logic [`XLEN-1:0]        s1_a;
    logic [`XLEN-1:0]        s1_b;

    // stage 2, product, only the low half is ever used
    logic                    s2_valid;
    logic [`ROB_TAG_LEN-1:0] s2_tag;
    logic [`XLEN-1:0]        s2_product;

    // stage 3, low half out
    logic                    s3_valid;
    logic [`ROB_TAG_LEN-1:0] s3_tag;
    logic [`XLEN-1:0]        s3_value;

    assign take = issue.valid && (issue.insn.fu == fu_mul);

    // valid chain, one insn per stage, no stall
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= take;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag     <= issue.insn.insn_tag;
        s1_a       <= issue.insn.value_src1;
        s1_b       <= issue.insn.value_src2;
        s2_tag     <= s1_tag;
        // sized by the lhs, low XLEN bits of the product
        s2_product <= s1_a * s1_b;
        s3_tag     <= s2_tag;
        s3_value   <= s2_product;
    end

    assign result = '{valid: s3_valid, tag: s3_tag, value: s3_value};

endmodule

//--- design/reservation_station.sv
`timescale 1ns/1ps

`include "rs_macros.svh"

module reservation_station import rs_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    // from dispatch
    input  logic                      load,
    input  rs_insn_t                  insn_load,
    // result lanes from the units and outside
    input  wakeup_t [`NUM_WAKEUP-1:0] wakeup,
    // squash one instruction by tag
    input  logic                      clear,
    input  logic [`ROB_TAG_LEN-1:0]   clear_tag,
    // registered issue slot
    output rs_entry_t                 insn_for_ex,
    output logic                      is_full
);

    localparam int IDX_W = $clog2(`RS_ENTRIES);
    localparam int CNT_W = $clog2(`RS_ENTRIES + 1);

    // slot 0 is the oldest, valid entries always packed low
    rs_entry_t entries      [`RS_ENTRIES];
    rs_entry_t entries_next [`RS_ENTRIES];
    rs_entry_t issue_next;

    logic [CNT_W-1:0] occupancy;
    logic             sel_found;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_squashed;
    logic             dup_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
            insn_for_ex.valid <= 1'b0;
        end else begin
            entries     <= entries_next;
            insn_for_ex <= issue_next;
        end
    end

    // valid count, equals first free slot since the array is compact
    always_comb begin
        occupancy = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            occupancy = occupancy + CNT_W'(entries[i].valid);
        end
    end

    assign is_full = (occupancy == CNT_W'(`RS_ENTRIES));

    // oldest ready entry, scanned from the young end so low index wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].insn.ready_src1
                    && entries[i].insn.ready_src2) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // squash on the same edge beats issue
    assign sel_squashed = clear && (entries[sel_idx].insn.insn_tag == clear_tag);

    always_comb begin
        issue_next       = entries[sel_idx];
        issue_next.valid = sel_found && !sel_squashed;
    end

    always_comb begin
        rs_entry_t staged [`RS_ENTRIES];
        int        rank   [`RS_ENTRIES];
        int        live;
        staged = entries;
        live   = 0;
        // new insn right behind the youngest valid one
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (load && (i == int'(occupancy))) begin
                staged[i].valid = 1'b1;
                staged[i].insn  = insn_load;
            end
        end
        // kill by tag, the fresh load included
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (clear && (staged[i].insn.insn_tag == clear_tag)) begin
                staged[i].valid = 1'b0;
            end
        end
        // issued entry leaves the station
        if (sel_found) begin
            staged[sel_idx].valid = 1'b0;
        end
        // destination slot of each survivor
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            rank[i] = live;
            if (staged[i].valid) begin
                live = live + 1;
            end
        end
        // stable compaction toward slot 0
        for (int d = 0; d < `RS_ENTRIES; d++) begin
            entries_next[d]       = staged[d];
            entries_next[d].valid = 1'b0;
            for (int i = d; i < `RS_ENTRIES; i++) begin
                if (staged[i].valid && (rank[i] == d)) begin
                    entries_next[d] = staged[i];
                end
            end
        end
        // tag match capture, only on sources still waiting
        for (int j = 0; j < `NUM_WAKEUP; j++) begin
            for (int d = 0; d < `RS_ENTRIES; d++) begin
                if (wakeup[j].valid && entries_next[d].valid) begin
                    if (!entries_next[d].insn.ready_src1
                            && (entries_next[d].insn.tag_src1 == wakeup[j].tag)) begin
                        entries_next[d].insn.value_src1 = wakeup[j].value;
                        entries_next[d].insn.ready_src1 = 1'b1;
                    end
                    if (!entries_next[d].insn.ready_src2
                            && (entries_next[d].insn.tag_src2 == wakeup[j].tag)) begin
                        entries_next[d].insn.value_src2 = wakeup[j].value;
                        entries_next[d].insn.ready_src2 = 1'b1;
                    end
                end
            end
        end
    end

    // pairwise tag compare over live entries
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            for (int k = i + 1; k < `RS_ENTRIES; k++) begin
                if (entries[i].valid && entries[k].valid
                        && (entries[i].insn.insn_tag == entries[k].insn.insn_tag)) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // dispatcher must hold off while full
    a_no_load_full: assert property (@(posedge clk) disable iff (reset) load |-> !is_full)
        else $error("load while station full");

    // dispatch never reuses a tag still in flight here
    a_unique_tag: assert property (@(posedge clk) disable iff (reset) !dup_tag)
        else $error("two live entries share one tag");

    a_issue_ready: assert property (@(posedge clk) disable iff (reset)
        insn_for_ex.valid |-> insn_for_ex.insn.ready_src1 && insn_for_ex.insn.ready_src2)
        else $error("issued entry with a pending source");

endmodule

//--- design/rs_exec_top.sv
`timescale 1ns/1ps

`include "rs_macros.svh"

module rs_exec_top import rs_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    // dispatch
    input  logic                    load,
    input  rs_insn_t                insn_load,
    // squash
    input  logic                    clear,
    input  logic [`ROB_TAG_LEN-1:0] clear_tag,
    // load data broadcast from outside
    input  wakeup_t                 ext_wakeup,
    output logic                    is_full,
    // unit results, also fed back as wakeups
    output wakeup_t                 alu_result,
    output wakeup_t                 mul_result
);

    wakeup_t [`NUM_WAKEUP-1:0] lanes;
    rs_entry_t                 insn_for_ex;

    // lane order fixed: alu, mul, external
    assign lanes[0] = alu_result;
    assign lanes[1] = mul_result;
    assign lanes[2] = ext_wakeup;

    reservation_station u_rs (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .insn_load   (insn_load),
        .wakeup      (lanes),
        .clear       (clear),
        .clear_tag   (clear_tag),
        .insn_for_ex (insn_for_ex),
        .is_full     (is_full)
    );

    // both units see every issue, each filters on fu
    alu_unit u_alu (
        .clk    (clk),
        .reset  (reset),
        .issue  (insn_for_ex),
        .result (alu_result)
    );

    mul_unit u_mul (
        .clk    (clk),
        .reset  (reset),
        .issue  (insn_for_ex),
        .result (mul_result)
    );

endmodule

//--- design/rs_macros.svh
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// data word width
`define XLEN 16
// rob tag width, 32 tags
`define ROB_TAG_LEN 5
// station depth
`define RS_ENTRIES 8
// broadcast lanes: 0 alu, 1 mul, 2 external (load data)
`define NUM_WAKEUP 3

`endif

//--- design/rs_pkg.sv
`include "rs_macros.svh"

package rs_pkg;

    // opcodes seen by the issue stage
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_mul = 2'd3
    } alu_op_t;

    // target unit, decided at dispatch
    typedef enum logic {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_kind_t;

    // decoded instruction as held in the station
    // value_srcN only meaningful once ready_srcN is set
    typedef struct packed {
        logic [`ROB_TAG_LEN-1:0] insn_tag;
        alu_op_t                 op;
        fu_kind_t                fu;
        logic [`ROB_TAG_LEN-1:0] tag_src1;
        logic                    ready_src1;
        logic [`XLEN-1:0]        value_src1;
        logic [`ROB_TAG_LEN-1:0] tag_src2;
        logic                    ready_src2;
        logic [`XLEN-1:0]        value_src2;
    } rs_insn_t;

    // one station slot, also the issue bundle
    typedef struct packed {
        logic     valid;
        rs_insn_t insn;
    } rs_entry_t;

    // result broadcast on one lane
    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_LEN-1:0] tag;
        logic [`XLEN-1:0]        value;
    } wakeup_t;

endpackage

//--- project.f
+incdir+design
design/rs_pkg.sv
design/reservation_station.sv
design/alu_unit.sv
design/mul_unit.sv
design/rs_exec_top.sv
sim/rs_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with verilator

root_dir=$(cd "$(dirname "$0")" && pwd)
cd "$root_dir" || exit 1

build_dir=obj_dir
log_file=sim.log

# compile rtl and testbench from the file list
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module rs_tb -Mdir "$build_dir" -o rs_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# run, keep everything in the log
"$build_dir/rs_tb_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

# verdict comes from the log
if grep -q "Testbench failed" "$log_file"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- sim/rs_tb.sv
`timescale 1ns/1ps

`include "rs_macros.svh"

module rs_tb import rs_pkg::*; ();

    localparam int TAGS      = 1 << `ROB_TAG_LEN;
    localparam int RUN_LIMIT = 400;

    typedef logic [`ROB_TAG_LEN-1:0] tag_t;
    typedef logic [`XLEN-1:0]        word_t;

    logic     clk;
    logic     reset;
    logic     load;
    rs_insn_t insn_load;
    logic     clear;
    tag_t     clear_tag;
    wakeup_t  ext_wakeup;
    logic     is_full;
    wakeup_t  alu_result;
    wakeup_t  mul_result;

    // program, indexed by tag; source kind 0 immediate, 1 tag
    int      prog_len;
    alu_op_t p_op      [TAGS];
    int      p_kind    [TAGS][2];
    tag_t    p_src_tag [TAGS][2];
    word_t   p_imm     [TAGS][2];

    // external broadcasts, tags placed after the program tags
    int   ext_count;
    tag_t ext_tag   [TAGS];
    int   ext_cycle [TAGS];
    bit   ext_sent  [TAGS];

    // reference values and bookkeeping by tag
    word_t exp_val  [TAGS];
    bit    expected [TAGS];
    bit    done     [TAGS];
    bit    killed   [TAGS];
    int    arrivals [$];
    string test_name;

    logic [31:0] rng_state = 32'd4;

    rs_exec_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .insn_load  (insn_load),
        .clear      (clear),
        .clear_tag  (clear_tag),
        .ext_wakeup (ext_wakeup),
        .is_full    (is_full),
        .alu_result (alu_result),
        .mul_result (mul_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // opcode rules, mul keeps the low XLEN bits
    function automatic word_t op_ref(alu_op_t op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    // walk the program in order, producers before consumers
    function automatic void build_reference();
        word_t src [2];
        for (int t = 0; t < prog_len; t++) begin
            for (int s = 0; s < 2; s++) begin
                src[s] = (p_kind[t][s] == 0) ? p_imm[t][s] : exp_val[p_src_tag[t][s]];
            end
            exp_val[t]  = op_ref(p_op[t], src[0], src[1]);
            expected[t] = 1'b1;
        end
    endfunction

    function automatic void clear_bookkeeping();
        for (int t = 0; t < TAGS; t++) begin
            expected[t] = 1'b0;
            done[t]     = 1'b0;
            killed[t]   = 1'b0;
            ext_sent[t] = 1'b0;
            p_kind[t]   = '{0, 0};
        end
        arrivals.delete();
    endfunction

    task automatic make_program(input int count, input int dep_pct, input int ext_pct,
                                input int n_ext, input bit alu_only);
        int r;
        clear_bookkeeping();
        prog_len  = count;
        ext_count = n_ext;
        for (int e = 0; e < n_ext; e++) begin
            ext_tag[e]           = tag_t'(count + e);
            exp_val[count + e]   = word_t'(next_rand());
            // late on purpose, most consumers already waiting
            ext_cycle[e]         = 10 + int'(next_rand() % 20);
        end
        for (int t = 0; t < count; t++) begin
            p_op[t] = alu_only ? alu_op_t'(2'(next_rand() % 3)) : alu_op_t'(2'(next_rand()));
            for (int s = 0; s < 2; s++) begin
                r               = int'(next_rand() % 100);
                p_imm[t][s]     = word_t'(next_rand());
                p_src_tag[t][s] = '0;
                p_kind[t][s]    = 0;
                if ((r < dep_pct) && (t > 0)) begin
                    p_kind[t][s]    = 1;
                    p_src_tag[t][s] = tag_t'(next_rand() % t);
                end else if ((r < dep_pct + ext_pct) && (n_ext > 0)) begin
                    p_kind[t][s]    = 1;
                    p_src_tag[t][s] = tag_t'(count + int'(next_rand() % n_ext));
                end
            end
        end
        build_reference();
    endtask

    // ready with value if immediate or already broadcast, else pending
    function automatic logic [`XLEN:0] resolve_src(int t, int s);
        if (p_kind[t][s] == 0) begin
            return {1'b1, p_imm[t][s]};
        end
        if (done[p_src_tag[t][s]]) begin
            return {1'b1, exp_val[p_src_tag[t][s]]};
        end
        return {1'b0, word_t'(0)};
    endfunction

    function automatic rs_insn_t make_insn(int t);
        rs_insn_t ins;
        ins          = '0;
        ins.insn_tag = tag_t'(t);
        ins.op       = p_op[t];
        ins.fu       = (p_op[t] == op_mul) ? fu_mul : fu_alu;
        ins.tag_src1 = p_src_tag[t][0];
        ins.tag_src2 = p_src_tag[t][1];
        {ins.ready_src1, ins.value_src1} = resolve_src(t, 0);
        {ins.ready_src2, ins.value_src2} = resolve_src(t, 1);
        return ins;
    endfunction

    function automatic bit work_left(int next);
        if (next < prog_len) begin
            return 1'b1;
        end
        for (int t = 0; t < TAGS; t++) begin
            if ((expected[t] && !done[t]) || ((t < ext_count) && !ext_sent[t])) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // one external lane, so at most one broadcast per cycle
    task automatic send_external(input int cyc);
        for (int e = 0; e < ext_count; e++) begin
            if (!ext_sent[e] && (cyc >= ext_cycle[e]) && !ext_wakeup.valid) begin
                ext_wakeup = '{valid: 1'b1, tag: ext_tag[e], value: exp_val[ext_tag[e]]};
                ext_sent[e] = 1'b1;
            end
        end
    endtask

    // dispatch the program, squash and check fullness at the given cycles
    task automatic run_program(input int max_gap, input int clear_cycle, input int kill_tag,
                               input int full_cycle);
        int cyc;
        int next;
        int load_at;
        cyc     = 0;
        next    = 0;
        load_at = 0;
        while (work_left(next)) begin
            if (cyc >= RUN_LIMIT) begin
                report_error($sformatf("timeout in test %s, results still missing", test_name));
            end
            @(posedge clk);
            #1;
            load       = 1'b0;
            clear      = 1'b0;
            ext_wakeup = '0;
            if (cyc == clear_cycle) begin
                clear            = 1'b1;
                clear_tag        = tag_t'(kill_tag);
                killed[kill_tag] = 1'b1;
                expected[kill_tag] = 1'b0;
            end
            send_external(cyc);
            if ((next < prog_len) && (cyc >= load_at) && !is_full) begin
                load      = 1'b1;
                insn_load = make_insn(next);
                next      = next + 1;
                load_at   = cyc + 1 + int'(next_rand() % (max_gap + 1));
            end
            if (cyc == full_cycle) begin
                assert (is_full)
                    else report_error($sformatf("station not full in test %s", test_name));
            end
            cyc = cyc + 1;
        end
        // quiet tail, a killed tag must stay silent
        repeat (12) @(posedge clk);
        #1;
    endtask

    task automatic check_result(input wakeup_t r);
        if (r.valid) begin
            assert (!killed[r.tag])
                else report_error($sformatf("killed tag %0d produced a result", r.tag));
            assert (expected[r.tag])
                else report_error($sformatf("unknown tag %0d on a result lane", r.tag));
            assert (!done[r.tag])
                else report_error($sformatf("duplicate result for tag %0d", r.tag));
            for (int s = 0; s < 2; s++) begin
                if (p_kind[r.tag][s] != 0) begin
                    assert (done[p_src_tag[r.tag][s]])
                        else report_error($sformatf("tag %0d done before its source %0d",
                                                    r.tag, p_src_tag[r.tag][s]));
                end
            end
            assert (r.value == exp_val[r.tag])
                else report_error($sformatf("MISMATCH %s tag %0d expected %h actual %h",
                                            test_name, r.tag, exp_val[r.tag], r.value));
            arrivals.push_back(int'(r.tag));
        end
    endtask

    // lanes are registered, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            check_result(alu_result);
            check_result(mul_result);
            if (alu_result.valid) begin
                done[alu_result.tag] = 1'b1;
            end
            if (mul_result.valid) begin
                done[mul_result.tag] = 1'b1;
            end
            if (ext_wakeup.valid) begin
                done[ext_wakeup.tag] = 1'b1;
            end
        end
    end

    initial begin
        load       = 1'b0;
        insn_load  = '0;
        clear      = 1'b0;
        clear_tag  = '0;
        ext_wakeup = '0;
        reset      = 1'b1;
        clear_bookkeeping();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!is_full && !alu_result.valid && !mul_result.valid)
            else report_error("outputs not idle after reset");

        test_name = "independent";
        make_program(20, 0, 0, 0, 1'b0);
        run_program(1, -1, 0, -1);

        test_name = "chains";
        make_program(24, 70, 0, 0, 1'b0);
        run_program(3, -1, 0, -1);

        test_name = "external";
        make_program(16, 30, 50, 4, 1'b0);
        run_program(2, -1, 0, -1);

        // three alu ops become ready together when one external tag arrives
        test_name = "oldest_first";
        make_program(3, 0, 0, 1, 1'b1);
        for (int t = 0; t < 3; t++) begin
            p_kind[t][0]    = 1;
            p_src_tag[t][0] = ext_tag[0];
        end
        build_reference();
        ext_cycle[0] = 6;
        run_program(0, -1, 0, -1);
        assert (arrivals.size() == 3)
            else report_error("oldest_first did not see three results");
        for (int i = 0; i < 3; i++) begin
            assert (arrivals[i] == i)
                else report_error($sformatf("MISMATCH %s slot %0d expected %0d actual %0d",
                                            test_name, i, i, arrivals[i]));
        end

        // all six wait on one tag, tag 2 killed before it is sent
        test_name = "squash";
        make_program(6, 0, 100, 1, 1'b0);
        ext_cycle[0] = 14;
        run_program(0, 8, 2, -1);

        // first eight block on the external tag and fill the station
        test_name = "full";
        make_program(20, 30, 0, 1, 1'b0);
        for (int t = 0; t < 8; t++) begin
            p_kind[t][0]    = 1;
            p_src_tag[t][0] = ext_tag[0];
            p_kind[t][1]    = 0;
        end
        build_reference();
        ext_cycle[0] = 14;
        run_program(0, -1, 0, 11);

        $display("Testbench passed");
        $finish;
    end

endmodule
